// File: vlog.f
+incdir+hw
hw/vidmcu_pkg.sv
hw/vid_reg_decode.sv
hw/hsync_gen.sv
hw/vsync_gen.sv
hw/de_gen.sv
hw/vid_addr_cnt.sv
hw/vidmcu_top.sv
tests/tb_vidmcu.sv

// File: Bender.yml
package:
  name: vidmcu

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/vidmcu_pkg.sv
      - hw/vid_reg_decode.sv
      - hw/hsync_gen.sv
      - hw/vsync_gen.sv
      - hw/de_gen.sv
      - hw/vid_addr_cnt.sv
      - hw/vidmcu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_vidmcu.sv

// File: tests/tb_vidmcu.sv
// ======================================================================
// Testbench for the video timing top level
// Reset state, register round trip, horizontal and vertical timing
// per mode, display window and video address counter checks
// ======================================================================
`timescale 1ns/100ps
`include "vidmcu_cfg.svh"

module tb_vidmcu;

    localparam int     CLK_HALF     = 4;                    // 8 ns clk32
    localparam longint FRAME_MAX_NS = 313 * 2048 * 8;       // Longest frame is PAL
    localparam longint WATCHDOG_NS  = 12 * FRAME_MAX_NS;    // Three frames per mode and margin

    localparam logic [23:0] A_BASE_H = 24'hFF8201;
    localparam logic [23:0] A_BASE_M = 24'hFF8203;
    localparam logic [23:0] A_CNT_H  = 24'hFF8205;
    localparam logic [23:0] A_CNT_M  = 24'hFF8207;
    localparam logic [23:0] A_CNT_L  = 24'hFF8209;
    localparam logic [23:0] A_SYNC   = 24'hFF820A;
    localparam logic [23:0] A_BASE_L = 24'hFF820D;
    localparam logic [23:0] A_HOFF   = 24'hFF820F;
    localparam logic [23:0] A_MODE   = 24'hFF8260;

    logic        clk32;
    logic        porb;
    logic [23:1] addr_i;
    logic [15:0] data_i;
    logic        as_i;
    logic        rw_i;
    logic        uds_i;
    logic        lds_i;
    logic [15:0] data_o;
    logic        hsync_n_o;
    logic        vsync_n_o;
    logic        de_o;
    logic        blank_n_o;

    int          seed;
    int          cyc;
    int          hs_last_fall;
    int          hs_period;     // clk32 cycles between the last two HSYNC falls
    int          hs_low;
    int          hs_count;
    int          de_lines;
    int          de_cycles;
    int          frame_words;   // Expected counter advance in this frame
    int          frame_hs;
    int          frame_de_lines;
    int          exp_line_ticks;
    logic        hs_q;
    logic        vs_q;
    logic        de_q;
    logic        window_check;
    logic [7:0]  hoff_val;
    event        hs_fall_ev;
    event        vs_fall_ev;
    event        de_fall_ev;

    vidmcu_top uut (
        .clk32(clk32),
        .porb(porb),
        .addr_i(addr_i),
        .data_i(data_i),
        .as_i(as_i),
        .rw_i(rw_i),
        .uds_i(uds_i),
        .lds_i(lds_i),
        .data_o(data_o),
        .hsync_n_o(hsync_n_o),
        .vsync_n_o(vsync_n_o),
        .de_o(de_o),
        .blank_n_o(blank_n_o)
    );

    always #CLK_HALF clk32 = ~clk32;

    task stop_with_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    // ==================================================================
    // CPU access tasks
    // ==================================================================
    task write_reg(input logic [23:0] a, input logic [15:0] d);
        @(posedge clk32);
        #1;
        addr_i = a[23:1];
        data_i = d;
        as_i   = 1'b1;
        rw_i   = 1'b0;
        uds_i  = ~a[0];             // Even byte on the upper lane
        lds_i  = a[0];
        @(posedge clk32);
        #1;
        as_i  = 1'b0;
        rw_i  = 1'b1;
        uds_i = 1'b0;
        lds_i = 1'b0;
    endtask

    task read_reg(input logic [23:0] a, output logic [15:0] d);
        @(posedge clk32);
        #1;
        addr_i = a[23:1];
        as_i   = 1'b1;
        rw_i   = 1'b1;
        uds_i  = ~a[0];
        lds_i  = a[0];
        @(negedge clk32);
        d = data_o;
        @(posedge clk32);
        #1;
        as_i  = 1'b0;
        uds_i = 1'b0;
        lds_i = 1'b0;
    endtask

    task check_read(input logic [23:0] a, input logic [15:0] exp, input string what);
        logic [15:0] val;
        read_reg(a, val);
        assert (val === exp) else
            stop_with_error($sformatf("Fail at %0t ns: %s read %h, expected %h",
                                      $time, what, val, exp));
    endtask

    // Resolution bit 9 wins over the sync bit
    task set_mode(input int m);
        write_reg(A_MODE, (m == 2) ? 16'h0200 : 16'h0000);
        write_reg(A_SYNC, (m == 1) ? 16'h0200 : 16'h0000);
    endtask

    // ==================================================================
    // Output monitor sampled on the falling edge
    // ==================================================================
    always @(negedge clk32) begin
        if (!porb) begin
            cyc          = 0;
            hs_last_fall = 0;
            hs_count     = 0;
            de_lines     = 0;
            de_cycles    = 0;
            frame_words  = 0;
            hs_q         = 1'b1;
            vs_q         = 1'b1;
            de_q         = 1'b0;
        end else begin
            cyc = cyc + 1;
            if (hs_q && !hsync_n_o) begin
                hs_period    = cyc - hs_last_fall;
                hs_last_fall = cyc;
                hs_count     = hs_count + 1;
                -> hs_fall_ev;
            end
            if (!hs_q && hsync_n_o)
                hs_low = cyc - hs_last_fall;
            if (de_o)
                de_cycles = de_cycles + 1;
            if (de_q && !de_o) begin
                if (window_check)
                    assert (de_cycles == exp_line_ticks * `TICK_DIV) else
                        stop_with_error($sformatf(
                            "Fail at %0t ns: DE line of %0d cycles, expected %0d ticks",
                            $time, de_cycles, exp_line_ticks));
                de_lines    = de_lines + 1;
                frame_words = frame_words + de_cycles / `TICK_DIV + hoff_val;
                de_cycles   = 0;
                -> de_fall_ev;
            end
            if (vs_q && !vsync_n_o) begin
                frame_hs       = hs_count;
                frame_de_lines = de_lines;
                hs_count       = 0;
                de_lines       = 0;
                frame_words    = 0;
                -> vs_fall_ev;
            end
            if (window_check)
                assert (blank_n_o || !de_o) else
                    stop_with_error($sformatf(
                        "Fail at %0t ns: DE high while BLANK_N low", $time));
            hs_q = hsync_n_o;
            vs_q = vsync_n_o;
            de_q = de_o;
        end
    end

    // ==================================================================
    // One timing set with register, timing, window and counter checks
    // ==================================================================
    task run_mode(input int m, input string name, input int hper, input int hlow,
                  input int lines, input int dlines, input int dticks);
        logic [31:0] rnd;
        logic [7:0]  hi;
        logic [7:0]  mid;
        logic [7:0]  lo;
        logic [20:0] base_word;
        logic [20:0] exp_word;
        logic [21:0] exp_byte;
        set_mode(m);
        rnd      = $random(seed);
        hi       = rnd[7:0];
        mid      = rnd[15:8];
        lo       = rnd[23:16];
        hoff_val = rnd[31:24];
        write_reg(A_BASE_H, {8'h00, hi});
        write_reg(A_BASE_M, {8'h00, mid});
        write_reg(A_BASE_L, {8'h00, lo});
        write_reg(A_HOFF, {8'h00, hoff_val});
        base_word = {hi[5:0], mid, lo[7:1]};       // Byte address bits 21:1
        check_read(A_BASE_H, {8'hFF, 2'b00, hi[5:0]}, "base high");
        check_read(A_BASE_M, {8'hFF, mid}, "base mid");
        check_read(A_BASE_L, {8'hFF, lo[7:1], 1'b0}, "base low");
        check_read(A_HOFF, {8'hFF, hoff_val}, "line offset");
        check_read(A_SYNC, (m == 1) ? 16'hFEFF : 16'hFCFF, "sync");
        check_read(A_MODE, (m == 2) ? 16'hFEFF : 16'hFCFF, "resolution");

        // Period between the second and third HSYNC falls
        repeat (3) @(hs_fall_ev);
        assert (hs_period == hper) else
            stop_with_error($sformatf("Fail at %0t ns: %s HSYNC period %0d, expected %0d",
                                      $time, name, hs_period, hper));
        assert (hs_low == hlow) else
            stop_with_error($sformatf("Fail at %0t ns: %s HSYNC low %0d, expected %0d",
                                      $time, name, hs_low, hlow));

        repeat (2) @(vs_fall_ev);
        exp_line_ticks = dticks;
        window_check   = 1'b1;
        while (de_lines < dlines)
            @(de_fall_ev);
        exp_word = base_word + frame_words;
        exp_byte = {exp_word, 1'b0};
        check_read(A_CNT_H, {8'hFF, 2'b00, exp_byte[21:16]}, "counter high");
        check_read(A_CNT_M, {8'hFF, exp_byte[15:8]}, "counter mid");
        check_read(A_CNT_L, {8'hFF, exp_byte[7:0]}, "counter low");
        @(vs_fall_ev);
        window_check = 1'b0;
        assert (frame_hs == lines) else
            stop_with_error($sformatf("Fail at %0t ns: %s frame of %0d lines, expected %0d",
                                      $time, name, frame_hs, lines));
        assert (frame_de_lines == dlines) else
            stop_with_error($sformatf("Fail at %0t ns: %s %0d DE lines, expected %0d",
                                      $time, name, frame_de_lines, dlines));
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_with_error("Watchdog expired, the run hung before all checks finished");
    end

    initial begin
        clk32          = 1'b0;
        porb           = 1'b0;
        addr_i         = '0;
        data_i         = '0;
        as_i           = 1'b0;
        rw_i           = 1'b1;
        uds_i          = 1'b0;
        lds_i          = 1'b0;
        seed           = 28049;
        hoff_val       = 8'h00;
        exp_line_ticks = 0;
        window_check   = 1'b0;
        repeat (10) @(posedge clk32);
        #1;
        porb = 1'b1;

        @(negedge clk32);
        assert (hsync_n_o && vsync_n_o && !de_o && blank_n_o) else
            stop_with_error($sformatf("Fail at %0t ns: outputs not idle after reset", $time));
        check_read(A_BASE_H, 16'hFF00, "reset base high");
        check_read(A_BASE_M, 16'hFF00, "reset base mid");
        check_read(A_BASE_L, 16'hFF00, "reset base low");
        check_read(A_CNT_H, 16'hFF00, "reset counter high");
        check_read(A_CNT_M, 16'hFF00, "reset counter mid");
        check_read(A_CNT_L, 16'hFF00, "reset counter low");
        check_read(A_HOFF, 16'hFF00, "reset line offset");
        check_read(A_SYNC, 16'hFCFF, "reset sync");
        check_read(A_MODE, 16'hFCFF, "reset resolution");

        run_mode(0, "PAL", 2048, 160, 313, 200, 84);
        run_mode(1, "NTSC", 2032, 160, 263, 200, 84);
        run_mode(2, "mono", 896, 96, 501, 400, 41);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: hw/vidmcu_top.sv
// ======================================================================
// Video timing top level
// Register decode, sync and enable generators, address counter
// ======================================================================
`timescale 1ns/100ps
`include "vidmcu_cfg.svh"

module vidmcu_top import vidmcu_pkg::*; (
    input  logic        clk32,
    input  logic        porb,
    input  logic [23:1] addr_i,
    input  logic [15:0] data_i,
    input  logic        as_i,
    input  logic        rw_i,
    input  logic        uds_i,
    input  logic        lds_i,
    output logic [15:0] data_o,
    output logic        hsync_n_o,
    output logic        vsync_n_o,
    output logic        de_o,
    output logic        blank_n_o
);

    video_mode_e        mode;
    reg_sel_e           sel;
    logic [`VID_AW-1:0] base;
    logic [7:0]         hoff;
    logic [7:0]         data_hi;
    logic               tick;
    logic               line_end;
    logic               frame_start;

    // Input side
    vid_reg_decode u_decode (
        .clk32(clk32),
        .porb(porb),
        .addr_i(addr_i),
        .data_i(data_i),
        .as_i(as_i),
        .rw_i(rw_i),
        .uds_i(uds_i),
        .lds_i(lds_i),
        .mode_o(mode),
        .base_o(base),
        .hoff_o(hoff),
        .sel_o(sel),
        .data_hi_o(data_hi)
    );

    // ==================================================================
    // Timing generators
    // ==================================================================
    hsync_gen u_hsync (
        .clk32(clk32),
        .porb(porb),
        .mode_i(mode),
        .tick_o(tick),
        .line_end_o(line_end),
        .hsync_n_o(hsync_n_o)
    );

    vsync_gen u_vsync (
        .clk32(clk32),
        .porb(porb),
        .mode_i(mode),
        .tick_i(tick),
        .line_end_i(line_end),
        .vsync_n_o(vsync_n_o),
        .frame_start_o(frame_start)
    );

    de_gen u_de (
        .clk32(clk32),
        .porb(porb),
        .mode_i(mode),
        .tick_i(tick),
        .line_end_i(line_end),
        .frame_start_i(frame_start),
        .de_o(de_o),
        .blank_n_o(blank_n_o)
    );

    // Output side
    vid_addr_cnt u_addr (
        .clk32(clk32),
        .porb(porb),
        .tick_i(tick),
        .de_i(de_o),
        .frame_start_i(frame_start),
        .base_i(base),
        .hoff_i(hoff),
        .sel_i(sel),
        .data_hi_i(data_hi),
        .data_o(data_o)
    );

endmodule

// File: hw/vid_addr_cnt.sv
// ======================================================================
// Video address counter
// Word counter with frame reload and line offset, CPU read data mux
// ======================================================================
`timescale 1ns/100ps
`include "vidmcu_cfg.svh"

module vid_addr_cnt import vidmcu_pkg::*; (
    input  logic                clk32,
    input  logic                porb,
    input  logic                tick_i,
    input  logic                de_i,
    input  logic                frame_start_i,
    input  logic [`VID_AW-1:0]  base_i,
    input  logic [7:0]          hoff_i,
    input  reg_sel_e            sel_i,
    input  logic [7:0]          data_hi_i,
    output logic [15:0]         data_o
);

    logic [`VID_AW-1:0] vid;
    logic               de_d;
    logic [7:0]         data_lo;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            vid  <= '0;
            de_d <= 1'b0;
        end else begin
            de_d <= de_i;
            if (frame_start_i)
                vid <= base_i;
            else if (de_d && !de_i)
                vid <= vid + `VID_AW'(hoff_i);  // End of displayed line
            else if (tick_i && de_i)
                vid <= vid + `VID_AW'(1);       // One word per displayed tick
        end
    end

    // ==================================================================
    // Read mux, lower byte
    // ==================================================================
    always_comb begin
        case (sel_i)
            SEL_BASE_H: data_lo = {2'b00, base_i[`VID_AW-1:15]};
            SEL_BASE_M: data_lo = base_i[14:7];
            SEL_BASE_L: data_lo = {base_i[6:0], 1'b0};
            SEL_CNT_H:  data_lo = {2'b00, vid[`VID_AW-1:15]};
            SEL_CNT_M:  data_lo = vid[14:7];
            SEL_CNT_L:  data_lo = {vid[6:0], 1'b0};
            SEL_HOFF:   data_lo = hoff_i;
            default:    data_lo = 8'hFF;
        endcase
    end

    assign data_o = {data_hi_i, data_lo};

endmodule

// File: hw/de_gen.sv
// ======================================================================
// Display enable and blanking
// Horizontal and vertical window counters, DE and BLANK_N
// ======================================================================
`timescale 1ns/100ps
`include "vidmcu_cfg.svh"

module de_gen import vidmcu_pkg::*; (
    input  logic        clk32,
    input  logic        porb,
    input  video_mode_e mode_i,
    input  logic        tick_i,
    input  logic        line_end_i,
    input  logic        frame_start_i,
    output logic        de_o,
    output logic        blank_n_o
);

    logic [6:0] hcnt;
    logic [8:0] vcnt;
    logic       hde;
    logic       vde;
    logic       hblank;     // High inside the visible area
    logic       vblank;
    logic [6:0] hde_on;
    logic [6:0] hde_off;
    logic [6:0] hbl_on;
    logic [8:0] vde_on;
    logic [8:0] vde_off;
    logic [8:0] vbl_on;
    logic [8:0] vbl_off;

    // Window points per mode, mono uses the PAL blank points
    always_comb begin
        hbl_on  = `HBLANK_SET_PAL;
        vbl_on  = `VBLANK_SET_PAL;
        vbl_off = `VBLANK_RESET_PAL;
        case (mode_i)
            MODE_NTSC: begin
                hde_on  = `HDE_SET_NTSC;
                hde_off = `HDE_RESET_NTSC;
                vde_on  = `VDE_SET_NTSC;
                vde_off = `VDE_RESET_NTSC;
                hbl_on  = `HBLANK_SET_NTSC;
                vbl_on  = `VBLANK_SET_NTSC;
                vbl_off = `VBLANK_RESET_NTSC;
            end
            MODE_MONO: begin
                hde_on  = `HDE_SET_MONO;
                hde_off = `HDE_RESET_MONO;
                vde_on  = `VDE_SET_MONO;
                vde_off = `VDE_RESET_MONO;
            end
            default: begin
                hde_on  = `HDE_SET_PAL;
                hde_off = `HDE_RESET_PAL;
                vde_on  = `VDE_SET_PAL;
                vde_off = `VDE_RESET_PAL;
            end
        endcase
    end

    // ==================================================================
    // Horizontal window, restarts at each line end
    // ==================================================================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hcnt   <= '0;
            hde    <= 1'b0;
            hblank <= 1'b0;
        end else if (tick_i) begin
            if (line_end_i) begin
                hcnt   <= '0;
                hde    <= 1'b0;
                hblank <= 1'b0;
            end else begin
                hcnt <= hcnt + 7'd1;
                if (hcnt == hde_on)        hde <= 1'b1;
                if (hcnt == hde_off)       hde <= 1'b0;
                if (hcnt == hbl_on)        hblank <= 1'b1;
                if (hcnt == `HBLANK_RESET) hblank <= 1'b0;
            end
        end
    end

    // ==================================================================
    // Vertical window, restarts at frame start
    // ==================================================================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            vcnt   <= '0;
            vde    <= 1'b0;
            vblank <= 1'b0;
        end else if (frame_start_i) begin
            vcnt   <= '0;
            vde    <= 1'b0;
            vblank <= 1'b0;
        end else if (line_end_i) begin
            vcnt <= vcnt + 9'd1;
            if (vcnt == vde_on)  vde <= 1'b1;
            if (vcnt == vde_off) vde <= 1'b0;
            if (vcnt == vbl_on)  vblank <= 1'b1;
            if (vcnt == vbl_off) vblank <= 1'b0;
        end
    end

    // Outputs move on ticks only
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            de_o      <= 1'b0;
            blank_n_o <= 1'b1;
        end else if (tick_i) begin
            de_o      <= hde & vde;
            blank_n_o <= (mode_i == MODE_MONO) | (hblank & vblank);   // Mono never blanked
        end
    end

endmodule

// File: hw/vsync_gen.sv
// ======================================================================
// Vertical timing
// Line counter with doubled load line, VSYNC and frame start pulse
// ======================================================================
`timescale 1ns/100ps
`include "vidmcu_cfg.svh"

module vsync_gen import vidmcu_pkg::*; (
    input  logic        clk32,
    input  logic        porb,
    input  video_mode_e mode_i,
    input  logic        tick_i,
    input  logic        line_end_i,
    output logic        vsync_n_o,
    output logic        frame_start_o
);

    logic [8:0] vcnt;
    logic       vload;          // Second load line
    logic [8:0] load_val;
    logic [8:0] sync_on;

    always_comb begin
        sync_on = `VSYNC_ON_COL;
        case (mode_i)
            MODE_NTSC: load_val = `VLOAD_NTSC;
            MODE_MONO: begin
                load_val = `VLOAD_MONO;
                sync_on  = `VSYNC_ON_MONO;
            end
            default:   load_val = `VLOAD_PAL;
        endcase
    end

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            vcnt          <= '0;
            vload         <= 1'b0;
            vsync_n_o     <= 1'b1;
            frame_start_o <= 1'b0;
        end else begin
            frame_start_o <= 1'b0;
            if (tick_i && line_end_i) begin
                if (vcnt == 9'd511 || vload) begin
                    vload     <= ~vload;
                    vcnt      <= load_val;
                    vsync_n_o <= 1'b1;      // Sync ends on reload
                end else begin
                    vcnt <= vcnt + 9'd1;
                end
                if (vcnt == sync_on) begin
                    vsync_n_o     <= 1'b0;
                    frame_start_o <= 1'b1;  // Same edge as the VSYNC fall
                end
            end
        end
    end

endmodule

// File: hw/hsync_gen.sv
// ======================================================================
// Horizontal timing
// 2 MHz tick divider, horizontal counter with doubled load cycle,
// HSYNC and the line end pulse
// ======================================================================
`timescale 1ns/100ps
`include "vidmcu_cfg.svh"

module hsync_gen import vidmcu_pkg::*; (
    input  logic        clk32,
    input  logic        porb,
    input  video_mode_e mode_i,
    output logic        tick_o,
    output logic        line_end_o,
    output logic        hsync_n_o
);

    localparam int DIV_W = $clog2(`TICK_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [6:0]       hcnt;
    logic             hload;        // Load value held for a second tick
    logic [6:0]       load_val;
    logic [6:0]       sync_on;
    logic [6:0]       sync_off;

    always_comb begin
        sync_on  = `HSYNC_ON_COL;
        sync_off = `HSYNC_OFF_COL;
        case (mode_i)
            MODE_NTSC: load_val = `HLOAD_NTSC;
            MODE_MONO: begin
                load_val = `HLOAD_MONO;
                sync_on  = `HSYNC_ON_MONO;
                sync_off = `HSYNC_OFF_MONO;
            end
            default:   load_val = `HLOAD_PAL;
        endcase
    end

    // Tick divider
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb)
            div_cnt <= '0;
        else if (tick_o)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign tick_o     = (div_cnt == DIV_W'(`TICK_DIV - 1));
    assign line_end_o = tick_o && (hcnt == 7'd127);     // Reload starts

    // ==================================================================
    // Horizontal counter and sync
    // ==================================================================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hcnt      <= '0;
            hload     <= 1'b0;
            hsync_n_o <= 1'b1;
        end else if (tick_o) begin
            if (hcnt == 7'd127 || hload) begin
                hload <= ~hload;
                hcnt  <= load_val;
            end else begin
                hcnt <= hcnt + 7'd1;
            end
            if (hcnt == sync_on)
                hsync_n_o <= 1'b0;
            if (hcnt == sync_off)
                hsync_n_o <= 1'b1;
        end
    end

endmodule

// File: hw/vid_reg_decode.sv
// ======================================================================
// CPU register decode for the FF82xx video page
// Base, line offset, sync and resolution registers, mode derivation
// and the upper read byte
// ======================================================================
`timescale 1ns/100ps
`include "vidmcu_cfg.svh"

module vid_reg_decode import vidmcu_pkg::*; (
    input  logic                clk32,
    input  logic                porb,
    input  logic [23:1]         addr_i,
    input  logic [15:0]         data_i,
    input  logic                as_i,
    input  logic                rw_i,
    input  logic                uds_i,
    input  logic                lds_i,
    output video_mode_e         mode_o,
    output logic [`VID_AW-1:0]  base_o,
    output logic [7:0]          hoff_o,
    output reg_sel_e            sel_o,
    output logic [7:0]          data_hi_o
);

    logic page;
    logic sync_r;       // Set selects 60 Hz
    logic mono_r;       // Set selects monochrome

    assign page = as_i && (addr_i[23:16] == 8'hFF) && (addr_i[15:8] == `REG_PAGE);

    // ==================================================================
    // Register select
    // ==================================================================
    always_comb begin
        sel_o = SEL_NONE;
        if (page) begin
            case (addr_i[7:1])
                7'h00: if (lds_i) sel_o = SEL_BASE_H;
                7'h01: if (lds_i) sel_o = SEL_BASE_M;
                7'h02: if (lds_i) sel_o = SEL_CNT_H;
                7'h03: if (lds_i) sel_o = SEL_CNT_M;
                7'h04: if (lds_i) sel_o = SEL_CNT_L;
                7'h05: if (uds_i) sel_o = SEL_SYNC;     // Even byte
                7'h06: if (lds_i) sel_o = SEL_BASE_L;
                7'h07: if (lds_i) sel_o = SEL_HOFF;
                7'h30: if (uds_i) sel_o = SEL_MODE;     // Even byte
                default: sel_o = SEL_NONE;
            endcase
        end
    end

    // ==================================================================
    // Writable registers
    // ==================================================================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            base_o <= '0;
            hoff_o <= '0;
            sync_r <= 1'b0;
            mono_r <= 1'b0;
        end else if (!rw_i) begin
            case (sel_o)
                SEL_BASE_H: base_o[`VID_AW-1:15] <= data_i[5:0];
                SEL_BASE_M: base_o[14:7] <= data_i[7:0];
                SEL_BASE_L: base_o[6:0] <= data_i[7:1];  // Word aligned
                SEL_HOFF:   hoff_o <= data_i[7:0];
                SEL_SYNC:   sync_r <= data_i[9];
                SEL_MODE:   mono_r <= data_i[9];
                default:    ;
            endcase
        end
    end

    // Mono overrides the sync bit
    always_comb begin
        if (mono_r)
            mode_o = MODE_MONO;
        else if (sync_r)
            mode_o = MODE_NTSC;
        else
            mode_o = MODE_PAL;
    end

    // Upper read byte, only bit 9 is live
    always_comb begin
        case (sel_o)
            SEL_SYNC: data_hi_o = {6'h3F, sync_r, 1'b0};
            SEL_MODE: data_hi_o = {6'h3F, mono_r, 1'b0};
            default:  data_hi_o = 8'hFF;
        endcase
    end

endmodule

// File: hw/vidmcu_pkg.sv
// ======================================================================
// Shared types of the video timing block
// Timing set and register select enums
// ======================================================================
package vidmcu_pkg;

    // Timing set, built from the resolution and sync bits
    typedef enum logic [1:0] {
        MODE_PAL  = 2'd0,       // Colour, 50 Hz
        MODE_NTSC = 2'd1,       // Colour, 60 Hz
        MODE_MONO = 2'd2        // Monochrome, 71 Hz
    } video_mode_e;

    // Addressed register in the FF82xx page
    typedef enum logic [3:0] {
        SEL_NONE   = 4'd0,
        SEL_BASE_H = 4'd1,      // FF8201
        SEL_BASE_M = 4'd2,      // FF8203
        SEL_BASE_L = 4'd3,      // FF820D
        SEL_CNT_H  = 4'd4,      // FF8205
        SEL_CNT_M  = 4'd5,      // FF8207
        SEL_CNT_L  = 4'd6,      // FF8209
        SEL_SYNC   = 4'd7,      // FF820A
        SEL_HOFF   = 4'd8,      // FF820F
        SEL_MODE   = 4'd9       // FF8260
    } reg_sel_e;

endpackage

// File: hw/vidmcu_cfg.svh
// ======================================================================
// Video timing constants
// Tick divider, address width, register page, counter load values,
// sync points and display/blank windows of the three timing sets
// ======================================================================
`ifndef VIDMCU_CFG_SVH
`define VIDMCU_CFG_SVH

`define VID_AW          21          // Word address, bits 21:1
`define TICK_DIV        16          // clk32 cycles per 2 MHz tick
`define REG_PAGE        8'h82       // FF82xx

// Horizontal counter runs from load value to 127
`define HLOAD_PAL       7'd1        // 128 ticks per line
`define HLOAD_NTSC      7'd2        // 127 ticks
`define HLOAD_MONO      7'd73       // 56 ticks
`define HSYNC_ON_COL    7'd101
`define HSYNC_OFF_COL   7'd111
`define HSYNC_ON_MONO   7'd121
`define HSYNC_OFF_MONO  7'd127

// Vertical counter runs from load value to 511
`define VLOAD_PAL       9'd200      // 313 lines per frame
`define VLOAD_NTSC      9'd250      // 263 lines
`define VLOAD_MONO      9'd12       // 501 lines
`define VSYNC_ON_COL    9'd508
`define VSYNC_ON_MONO   9'd510

// Display windows, counted from line end and frame start
`define HDE_SET_PAL     7'd12
`define HDE_RESET_PAL   7'd96
`define HDE_SET_NTSC    7'd11
`define HDE_RESET_NTSC  7'd95
`define HDE_SET_MONO    7'd2
`define HDE_RESET_MONO  7'd43
`define VDE_SET_PAL     9'd62
`define VDE_RESET_PAL   9'd262
`define VDE_SET_NTSC    9'd33
`define VDE_RESET_NTSC  9'd233
`define VDE_SET_MONO    9'd35
`define VDE_RESET_MONO  9'd435

// Blank windows, colour only
`define HBLANK_SET_PAL    7'd9
`define HBLANK_SET_NTSC   7'd8
`define HBLANK_RESET      7'd114
`define VBLANK_SET_PAL    9'd24
`define VBLANK_RESET_PAL  9'd307
`define VBLANK_SET_NTSC   9'd15
`define VBLANK_RESET_NTSC 9'd257

`endif
